/* rtl/me_axil_pkg.sv */
`default_nettype none

package me_axil_pkg;

  // Widths are fixed by the 32-bit AXI-Lite port
  localparam int addr_width_lp = 32;
  localparam int data_width_lp = 32;
  localparam int strb_width_lp = data_width_lp / 8;
  localparam int lane_width_lp = $clog2(strb_width_lp);
  localparam int tag_width_lp  = 8;

  // Forward message opcodes
  typedef enum logic [1:0] {
    e_mem_rd    = 2'b00,
    e_mem_wr    = 2'b01,
    e_mem_uc_rd = 2'b10,
    e_mem_uc_wr = 2'b11
  } mem_msg_e;

  // Request size, log2 of the byte count
  typedef enum logic [1:0] {
    e_size_1 = 2'b00,
    e_size_2 = 2'b01,
    e_size_4 = 2'b10
  } mem_size_e;

  // Message header, echoed unchanged on the reverse stream
  typedef struct packed {
    mem_msg_e                 msg_type;
    mem_size_e                size;
    logic [addr_width_lp-1:0] addr;
    logic [tag_width_lp-1:0]  payload;
  } mem_hdr_s;

  // Single AXI-Lite transaction as seen by the engine
  typedef struct packed {
    logic                     write;
    logic [addr_width_lp-1:0] addr;
    logic [data_width_lp-1:0] wdata;
    logic [strb_width_lp-1:0] wstrb;
  } axil_req_s;

  // Channel sequencing of the AXI-Lite engine
  typedef enum logic [2:0] {
    e_idle,
    e_wr_addr_data,
    e_wr_resp,
    e_rd_addr,
    e_rd_data
  } engine_state_e;

endpackage

`default_nettype wire

/* rtl/fwd_decode.sv */
`default_nettype none

module fwd_decode
  import me_axil_pkg::*;
(
  input  wire                      clk_i,
  input  wire                      arst_n_i,

  input  wire mem_hdr_s            mem_fwd_header_i,
  input  wire [data_width_lp-1:0]  mem_fwd_data_i,
  input  wire                      mem_fwd_v_i,
  output logic                     mem_fwd_ready_and_o,

  input  wire                      req_take_i,
  input  wire                      rev_sent_i,
  output axil_req_s                req_o,
  output logic                     req_v_o,
  output mem_hdr_s                 hdr_o
);

  logic                     full_r;
  logic                     req_v_r;
  mem_hdr_s                 hdr_r;
  axil_req_s                req_r;
  axil_req_s                req_n;
  logic                     fwd_fire;
  logic [lane_width_lp-1:0] lane;
  logic [strb_width_lp-1:0] size_mask;
  logic [data_width_lp-1:0] wdata_rep;

  // Only one request outstanding, so accept only into an empty slot
  assign mem_fwd_ready_and_o = ~full_r;
  assign fwd_fire            = mem_fwd_v_i & mem_fwd_ready_and_o;
  assign lane                = mem_fwd_header_i.addr[lane_width_lp-1:0];

  // Byte mask by size, data replicated so every lane sees its bytes
  always_comb
  begin
    case (mem_fwd_header_i.size)
      e_size_1:
      begin
        size_mask = strb_width_lp'(4'b0001);
        wdata_rep = {strb_width_lp{mem_fwd_data_i[7:0]}};
      end
      e_size_2:
      begin
        size_mask = strb_width_lp'(4'b0011);
        wdata_rep = {(strb_width_lp / 2){mem_fwd_data_i[15:0]}};
      end
      default:
      begin
        size_mask = strb_width_lp'(4'b1111);
        wdata_rep = mem_fwd_data_i;
      end
    endcase

    req_n.write = mem_fwd_header_i.msg_type inside {e_mem_wr, e_mem_uc_wr};
    req_n.addr  = mem_fwd_header_i.addr;
    req_n.wdata = wdata_rep;
    req_n.wstrb = size_mask << lane;
  end

  // Slot stays full until the reverse message has been taken
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      full_r  <= 1'b0;
      req_v_r <= 1'b0;
    end
    else
    begin
      if (fwd_fire)
        full_r <= 1'b1;
      else if (rev_sent_i)
        full_r <= 1'b0;

      if (fwd_fire)
        req_v_r <= 1'b1;
      else if (req_take_i)
        req_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (fwd_fire)
    begin
      hdr_r <= mem_fwd_header_i;
      req_r <= req_n;
    end
  end

  assign req_o   = req_r;
  assign req_v_o = req_v_r;
  assign hdr_o   = hdr_r;

endmodule

`default_nettype wire

/* rtl/axil_engine.sv */
`default_nettype none

module axil_engine
  import me_axil_pkg::*;
(
  input  wire                      clk_i,
  input  wire                      arst_n_i,

  input  wire axil_req_s           req_i,
  input  wire                      req_v_i,
  output logic                     req_take_o,
  output logic                     done_o,
  output logic [data_width_lp-1:0] rdata_o,

  // Write address channel
  output logic [addr_width_lp-1:0] m_axil_awaddr_o,
  output logic                     m_axil_awvalid_o,
  input  wire                      m_axil_awready_i,

  // Write data channel
  output logic [data_width_lp-1:0] m_axil_wdata_o,
  output logic [strb_width_lp-1:0] m_axil_wstrb_o,
  output logic                     m_axil_wvalid_o,
  input  wire                      m_axil_wready_i,

  // Write response channel
  input  wire                      m_axil_bvalid_i,
  output logic                     m_axil_bready_o,

  // Read address channel
  output logic [addr_width_lp-1:0] m_axil_araddr_o,
  output logic                     m_axil_arvalid_o,
  input  wire                      m_axil_arready_i,

  // Read data channel
  input  wire [data_width_lp-1:0]  m_axil_rdata_i,
  input  wire                      m_axil_rvalid_i,
  output logic                     m_axil_rready_o
);

  engine_state_e            state_r;
  engine_state_e            state_n;
  logic                     aw_pend_r;
  logic                     w_pend_r;
  logic                     aw_fire;
  logic                     w_fire;
  logic                     b_fire;
  logic                     ar_fire;
  logic                     r_fire;
  logic                     aw_clear;
  logic                     w_clear;

  assign req_take_o = (state_r == e_idle) & req_v_i;

  assign aw_fire = m_axil_awvalid_o & m_axil_awready_i;
  assign w_fire  = m_axil_wvalid_o & m_axil_wready_i;
  assign b_fire  = m_axil_bvalid_i & m_axil_bready_o;
  assign ar_fire = m_axil_arvalid_o & m_axil_arready_i;
  assign r_fire  = m_axil_rvalid_i & m_axil_rready_o;

  // Address or data may be accepted first, or both in one cycle
  assign aw_clear = aw_fire | ~aw_pend_r;
  assign w_clear  = w_fire | ~w_pend_r;

  // Request fields are held by decode until the reverse message leaves
  assign m_axil_awaddr_o  = req_i.addr;
  assign m_axil_wdata_o   = req_i.wdata;
  assign m_axil_wstrb_o   = req_i.wstrb;
  assign m_axil_araddr_o  = req_i.addr;

  assign m_axil_awvalid_o = aw_pend_r;
  assign m_axil_wvalid_o  = w_pend_r;
  assign m_axil_bready_o  = (state_r == e_wr_resp);
  assign m_axil_arvalid_o = (state_r == e_rd_addr);
  assign m_axil_rready_o  = (state_r == e_rd_data);

  assign done_o  = b_fire | r_fire;
  // Valid together with done_o on the R transfer, registered by rev_pack
  assign rdata_o = m_axil_rdata_i;

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_idle:
        if (req_v_i)
          state_n = req_i.write ? e_wr_addr_data : e_rd_addr;
      e_wr_addr_data:
        if (aw_clear && w_clear)
          state_n = e_wr_resp;
      e_wr_resp:
        if (b_fire)
          state_n = e_idle;
      e_rd_addr:
        if (ar_fire)
          state_n = e_rd_data;
      e_rd_data:
        if (r_fire)
          state_n = e_idle;
      default:
        state_n = e_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_r   <= e_idle;
      aw_pend_r <= 1'b0;
      w_pend_r  <= 1'b0;
    end
    else
    begin
      state_r <= state_n;
      if (req_take_o && req_i.write)
      begin
        aw_pend_r <= 1'b1;
        w_pend_r  <= 1'b1;
      end
      else
      begin
        if (aw_fire)
          aw_pend_r <= 1'b0;
        if (w_fire)
          w_pend_r <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/rev_pack.sv */
`default_nettype none

module rev_pack
  import me_axil_pkg::*;
(
  input  wire                      clk_i,
  input  wire                      arst_n_i,

  input  wire mem_hdr_s            hdr_i,
  input  wire                      done_i,
  input  wire [data_width_lp-1:0]  rdata_i,

  output mem_hdr_s                 mem_rev_header_o,
  output logic [data_width_lp-1:0] mem_rev_data_o,
  output logic                     mem_rev_v_o,
  input  wire                      mem_rev_ready_and_i,
  output logic                     rev_sent_o
);

  logic                     v_r;
  logic [data_width_lp-1:0] data_r;
  logic [data_width_lp-1:0] data_n;
  logic [data_width_lp-1:0] rd_packed;
  logic [lane_width_lp-1:0] lane;
  logic                     is_write;

  assign lane     = hdr_i.addr[lane_width_lp-1:0];
  assign is_write = hdr_i.msg_type inside {e_mem_wr, e_mem_uc_wr};

  // Pick the addressed bytes and replicate them over the word
  always_comb
  begin
    case (hdr_i.size)
      e_size_1:
        rd_packed = {strb_width_lp{rdata_i[{lane, 3'b000} +: 8]}};
      e_size_2:
        rd_packed = {(strb_width_lp / 2){rdata_i[{lane[1], 4'b0000} +: 16]}};
      default:
        rd_packed = rdata_i;
    endcase

    // Write acknowledgements carry no data
    data_n = is_write ? '0 : rd_packed;
  end

  assign rev_sent_o = v_r & mem_rev_ready_and_i;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      v_r <= 1'b0;
    else if (done_i)
      v_r <= 1'b1;
    else if (rev_sent_o)
      v_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (done_i)
      data_r <= data_n;
  end

  // Header held by decode until rev_sent_o frees the slot
  assign mem_rev_header_o = hdr_i;
  assign mem_rev_data_o   = data_r;
  assign mem_rev_v_o      = v_r;

endmodule

`default_nettype wire

/* rtl/me_axil_bridge.sv */
`default_nettype none

module me_axil_bridge
  import me_axil_pkg::*;
(
  input  wire                      clk_i,
  input  wire                      arst_n_i,

  // Forward stream
  input  wire mem_hdr_s            mem_fwd_header_i,
  input  wire [data_width_lp-1:0]  mem_fwd_data_i,
  input  wire                      mem_fwd_v_i,
  output logic                     mem_fwd_ready_and_o,

  // Reverse stream
  output mem_hdr_s                 mem_rev_header_o,
  output logic [data_width_lp-1:0] mem_rev_data_o,
  output logic                     mem_rev_v_o,
  input  wire                      mem_rev_ready_and_i,

  // AXI-Lite master
  output logic [addr_width_lp-1:0] m_axil_awaddr_o,
  output logic                     m_axil_awvalid_o,
  input  wire                      m_axil_awready_i,
  output logic [data_width_lp-1:0] m_axil_wdata_o,
  output logic [strb_width_lp-1:0] m_axil_wstrb_o,
  output logic                     m_axil_wvalid_o,
  input  wire                      m_axil_wready_i,
  input  wire                      m_axil_bvalid_i,
  output logic                     m_axil_bready_o,
  output logic [addr_width_lp-1:0] m_axil_araddr_o,
  output logic                     m_axil_arvalid_o,
  input  wire                      m_axil_arready_i,
  input  wire [data_width_lp-1:0]  m_axil_rdata_i,
  input  wire                      m_axil_rvalid_i,
  output logic                     m_axil_rready_o
);

  axil_req_s                req;
  logic                     req_v;
  logic                     req_take;
  logic                     done;
  logic [data_width_lp-1:0] rdata;
  mem_hdr_s                 hdr;
  logic                     rev_sent;

  fwd_decode decode (
    .clk_i               (clk_i),
    .arst_n_i            (arst_n_i),
    .mem_fwd_header_i    (mem_fwd_header_i),
    .mem_fwd_data_i      (mem_fwd_data_i),
    .mem_fwd_v_i         (mem_fwd_v_i),
    .mem_fwd_ready_and_o (mem_fwd_ready_and_o),
    .req_take_i          (req_take),
    .rev_sent_i          (rev_sent),
    .req_o               (req),
    .req_v_o             (req_v),
    .hdr_o               (hdr)
  );

  axil_engine engine (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .req_i            (req),
    .req_v_i          (req_v),
    .req_take_o       (req_take),
    .done_o           (done),
    .rdata_o          (rdata),
    .m_axil_awaddr_o  (m_axil_awaddr_o),
    .m_axil_awvalid_o (m_axil_awvalid_o),
    .m_axil_awready_i (m_axil_awready_i),
    .m_axil_wdata_o   (m_axil_wdata_o),
    .m_axil_wstrb_o   (m_axil_wstrb_o),
    .m_axil_wvalid_o  (m_axil_wvalid_o),
    .m_axil_wready_i  (m_axil_wready_i),
    .m_axil_bvalid_i  (m_axil_bvalid_i),
    .m_axil_bready_o  (m_axil_bready_o),
    .m_axil_araddr_o  (m_axil_araddr_o),
    .m_axil_arvalid_o (m_axil_arvalid_o),
    .m_axil_arready_i (m_axil_arready_i),
    .m_axil_rdata_i   (m_axil_rdata_i),
    .m_axil_rvalid_i  (m_axil_rvalid_i),
    .m_axil_rready_o  (m_axil_rready_o)
  );

  rev_pack pack (
    .clk_i               (clk_i),
    .arst_n_i            (arst_n_i),
    .hdr_i               (hdr),
    .done_i              (done),
    .rdata_i             (rdata),
    .mem_rev_header_o    (mem_rev_header_o),
    .mem_rev_data_o      (mem_rev_data_o),
    .mem_rev_v_o         (mem_rev_v_o),
    .mem_rev_ready_and_i (mem_rev_ready_and_i),
    .rev_sent_o          (rev_sent)
  );

endmodule

`default_nettype wire

/* verification/me_axil_chk.sv */
`default_nettype none

module me_axil_chk
  import me_axil_pkg::*;
(
  input wire                     clk_i,
  input wire                     arst_n_i,
  input wire                     fwd_ready_i,
  input wire                     rev_v_i,
  input wire                     rev_ready_i,
  input wire mem_hdr_s           rev_header_i,
  input wire [data_width_lp-1:0] rev_data_i,
  input wire                     awvalid_i,
  input wire                     awready_i,
  input wire                     wvalid_i,
  input wire                     wready_i,
  input wire                     arvalid_i,
  input wire                     arready_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // A held request blocks new forward traffic
  a_one_in_flight: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(rev_v_i && fwd_ready_i)) else $error("reverse valid while forward ready");

  a_aw_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    awvalid_i && !awready_i |=> awvalid_i) else $error("awvalid dropped before awready");

  a_w_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wvalid_i && !wready_i |=> wvalid_i) else $error("wvalid dropped before wready");

  a_ar_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    arvalid_i && !arready_i |=> arvalid_i) else $error("arvalid dropped before arready");

  // Reverse message frozen while stalled
  a_rev_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rev_v_i && !rev_ready_i |=> rev_v_i && $stable(rev_header_i) && $stable(rev_data_i))
    else $error("reverse message changed while stalled");

  a_reset_idle: assert property (@(posedge clk_i)
    $rose(arst_n_i) |-> !(awvalid_i || wvalid_i || arvalid_i || rev_v_i))
    else $error("valid high right after reset release");

endmodule

bind me_axil_bridge me_axil_chk chk (
  .clk_i        (clk_i),
  .arst_n_i     (arst_n_i),
  .fwd_ready_i  (mem_fwd_ready_and_o),
  .rev_v_i      (mem_rev_v_o),
  .rev_ready_i  (mem_rev_ready_and_i),
  .rev_header_i (mem_rev_header_o),
  .rev_data_i   (mem_rev_data_o),
  .awvalid_i    (m_axil_awvalid_o),
  .awready_i    (m_axil_awready_i),
  .wvalid_i     (m_axil_wvalid_o),
  .wready_i     (m_axil_wready_i),
  .arvalid_i    (m_axil_arvalid_o),
  .arready_i    (m_axil_arready_i)
);

`default_nettype wire

/* verification/me_axil_tb.sv */
`default_nettype none

module me_axil_tb
  import me_axil_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int clk_period_lp = 100;
  localparam longint watchdog_cycles_lp = 6 * 40 * 60;

  logic clk_i = 1'b0;
  logic arst_n_i;
  mem_hdr_s mem_fwd_header_i;
  logic [data_width_lp-1:0] mem_fwd_data_i;
  logic mem_fwd_v_i;
  logic mem_fwd_ready_and_o;
  mem_hdr_s mem_rev_header_o;
  logic [data_width_lp-1:0] mem_rev_data_o;
  logic mem_rev_v_o;
  logic mem_rev_ready_and_i;
  logic [addr_width_lp-1:0] m_axil_awaddr_o;
  logic m_axil_awvalid_o;
  logic m_axil_awready_i;
  logic [data_width_lp-1:0] m_axil_wdata_o;
  logic [strb_width_lp-1:0] m_axil_wstrb_o;
  logic m_axil_wvalid_o;
  logic m_axil_wready_i;
  logic m_axil_bvalid_i;
  logic m_axil_bready_o;
  logic [addr_width_lp-1:0] m_axil_araddr_o;
  logic m_axil_arvalid_o;
  logic m_axil_arready_i;
  logic [data_width_lp-1:0] m_axil_rdata_i;
  logic m_axil_rvalid_i;
  logic m_axil_rready_o;

  // Slave memory and the expected view of it
  logic [data_width_lp-1:0] axi_mem [256];
  logic [data_width_lp-1:0] shadow [256];
  logic aw_have;
  logic w_have;
  logic ar_have;
  logic aw_fire;
  logic w_fire;
  logic b_fire;
  logic ar_fire;
  logic r_fire;
  logic [addr_width_lp-1:0] awaddr_q;
  logic [addr_width_lp-1:0] araddr_q;
  logic [data_width_lp-1:0] wdata_q;
  logic [strb_width_lp-1:0] wstrb_q;
  logic stall_en;
  int errors;
  int checks;
  int tests_run;

  me_axil_bridge uut (.*);

  always #(clk_period_lp / 2) clk_i = ~clk_i;

  function automatic logic [31:0] fill_word(input logic [7:0] idx);
    return {idx ^ 8'ha5, ~idx, idx, idx + 8'h3c};
  endfunction

  function automatic logic allow_progress();
    return !stall_en || ($urandom % 4 != 0);
  endfunction

  function automatic mem_hdr_s make_hdr(input mem_msg_e op, input mem_size_e size,
                                        input logic [7:0] idx, input logic [1:0] lane,
                                        input logic [7:0] tag);
    mem_hdr_s h;
    h.msg_type = op;
    h.size     = size;
    h.addr     = {22'h0, idx, lane};
    h.payload  = tag;
    return h;
  endfunction

  // Lane rule on the shadow; returns the expected reverse data
  function automatic logic [31:0] shadow_access(input mem_hdr_s hdr, input logic [31:0] data);
    logic [7:0] idx;
    logic [1:0] lane;
    logic [31:0] word;
    idx  = hdr.addr[9:2];
    lane = hdr.addr[1:0];
    word = shadow[idx];
    if (hdr.msg_type == e_mem_wr || hdr.msg_type == e_mem_uc_wr)
    begin
      case (hdr.size)
        e_size_1: word[8*lane +: 8] = data[7:0];
        e_size_2: word[8*lane +: 16] = data[15:0];
        default:  word = data;
      endcase
      shadow[idx] = word;
      return '0;
    end
    case (hdr.size)
      e_size_1: return {4{word[8*lane +: 8]}};
      e_size_2: return {2{word[8*lane +: 16]}};
      default:  return word;
    endcase
  endfunction

  task automatic check_hdr(input string sig, input mem_hdr_s got, input mem_hdr_s exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, sig, got, exp);
    end
  endtask

  task automatic check_data(input string sig, input logic [data_width_lp-1:0] got,
                            input logic [data_width_lp-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, sig, got, exp);
    end
  endtask

  task automatic check_flag(input string sig, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("mismatch at %0t: %s got %b expected %b", $time, sig, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    $display("%s finished with %0d errors", name, errors - errors_before);
  endtask

  // Entered and left on a falling edge
  task automatic send_and_check(input mem_hdr_s hdr, input logic [31:0] data);
    mem_hdr_s got_hdr;
    logic [31:0] got_data;
    logic [31:0] exp_data;
    logic sent;
    logic taken;
    exp_data = shadow_access(hdr, data);
    mem_fwd_header_i = hdr;
    mem_fwd_data_i   = data;
    mem_fwd_v_i      = 1'b1;
    sent = 1'b0;
    while (!sent)
    begin
      sent = mem_fwd_ready_and_o;
      @(posedge clk_i);
      @(negedge clk_i);
    end
    mem_fwd_v_i = 1'b0;
    taken = 1'b0;
    while (!taken)
    begin
      mem_rev_ready_and_i = stall_en ? ($urandom % 3 != 0) : 1'b1;
      if (mem_rev_v_o && mem_rev_ready_and_i)
      begin
        taken    = 1'b1;
        got_hdr  = mem_rev_header_o;
        got_data = mem_rev_data_o;
      end
      @(posedge clk_i);
      @(negedge clk_i);
    end
    check_hdr("mem_rev_header_o", got_hdr, hdr);
    check_data("mem_rev_data_o", got_data, exp_data);
  endtask

  task automatic test_reset_idle();
    int e0;
    e0 = errors;
    check_flag("mem_rev_v_o", mem_rev_v_o, 1'b0);
    check_flag("m_axil_awvalid_o", m_axil_awvalid_o, 1'b0);
    check_flag("m_axil_wvalid_o", m_axil_wvalid_o, 1'b0);
    check_flag("m_axil_bready_o", m_axil_bready_o, 1'b0);
    check_flag("m_axil_arvalid_o", m_axil_arvalid_o, 1'b0);
    check_flag("m_axil_rready_o", m_axil_rready_o, 1'b0);
    check_flag("mem_fwd_ready_and_o", mem_fwd_ready_and_o, 1'b1);
    report_test("reset_idle", e0);
  endtask

  task automatic test_word_round_trip();
    int e0;
    e0 = errors;
    send_and_check(make_hdr(e_mem_uc_wr, e_size_4, 8'h05, 2'd0, 8'h01), 32'hdead_beef);
    send_and_check(make_hdr(e_mem_rd, e_size_4, 8'h05, 2'd0, 8'h02), 32'h0);
    send_and_check(make_hdr(e_mem_wr, e_size_4, 8'h06, 2'd0, 8'h03), 32'h1234_5678);
    send_and_check(make_hdr(e_mem_uc_rd, e_size_4, 8'h06, 2'd0, 8'h04), 32'h0);
    report_test("word_round_trip", e0);
  endtask

  task automatic test_sub_word_writes();
    int e0;
    e0 = errors;
    // One word per write, so a spill into any other lane stays visible
    for (int l = 0; l < 4; l++)
      send_and_check(make_hdr(e_mem_wr, e_size_1, 8'(8'h20 + l), 2'(l), 8'(l)), $urandom);
    send_and_check(make_hdr(e_mem_uc_wr, e_size_2, 8'h24, 2'd0, 8'h10), $urandom);
    send_and_check(make_hdr(e_mem_wr, e_size_2, 8'h25, 2'd2, 8'h11), $urandom);
    for (int i = 0; i < 6; i++)
      send_and_check(make_hdr(i[0] ? e_mem_uc_rd : e_mem_rd, e_size_4, 8'(8'h20 + i), 2'd0,
                              8'(8'h12 + i)), 32'h0);
    report_test("sub_word_writes", e0);
  endtask

  task automatic test_sub_word_reads();
    int e0;
    e0 = errors;
    for (int l = 0; l < 4; l++)
      send_and_check(make_hdr(e_mem_uc_rd, e_size_1, 8'h30, 2'(l), 8'(l)), 32'h0);
    send_and_check(make_hdr(e_mem_rd, e_size_2, 8'h31, 2'd0, 8'h20), 32'h0);
    send_and_check(make_hdr(e_mem_rd, e_size_2, 8'h31, 2'd2, 8'h21), 32'h0);
    report_test("sub_word_reads", e0);
  endtask

  task automatic test_back_pressure();
    int e0;
    mem_size_e size;
    logic [1:0] lane;
    e0 = errors;
    stall_en = 1'b1;
    for (int i = 0; i < 40; i++)
    begin
      size = mem_size_e'(2'($urandom_range(2, 0)));
      lane = (size == e_size_1) ? 2'($urandom) : (size == e_size_2) ? {1'($urandom), 1'b0} : 2'd0;
      send_and_check(make_hdr(mem_msg_e'(2'($urandom)), size, 8'($urandom % 16), lane,
                              8'(i)), $urandom);
    end
    stall_en = 1'b0;
    report_test("back_pressure", e0);
  endtask

  task automatic test_payload_tags();
    int e0;
    e0 = errors;
    for (int i = 0; i < 8; i++)
      send_and_check(make_hdr(i[0] ? e_mem_rd : e_mem_wr, e_size_4, 8'h40, 2'd0,
                              8'(8'h80 + i)), $urandom);
    report_test("payload_tags", e0);
  endtask

  // AXI-Lite slave: transfers seen one falling edge before are applied first
  always @(negedge clk_i)
  begin
    if (aw_fire)
      aw_have = 1'b1;
    if (w_fire)
      w_have = 1'b1;
    if (b_fire)
      m_axil_bvalid_i = 1'b0;
    if (ar_fire)
      ar_have = 1'b1;
    if (r_fire)
      m_axil_rvalid_i = 1'b0;
    if (aw_have && w_have && !m_axil_bvalid_i && allow_progress())
    begin
      for (int b = 0; b < strb_width_lp; b++)
        if (wstrb_q[b])
          axi_mem[awaddr_q[9:2]][8*b +: 8] = wdata_q[8*b +: 8];
      m_axil_bvalid_i = 1'b1;
      aw_have = 1'b0;
      w_have  = 1'b0;
    end
    if (ar_have && !m_axil_rvalid_i && allow_progress())
    begin
      m_axil_rdata_i  = axi_mem[araddr_q[9:2]];
      m_axil_rvalid_i = 1'b1;
      ar_have = 1'b0;
    end
    m_axil_awready_i = !aw_have && allow_progress();
    m_axil_wready_i  = !w_have && allow_progress();
    m_axil_arready_i = !ar_have && allow_progress();
    // DUT valids and readies are registered, so these fire on the next rising edge
    aw_fire = m_axil_awvalid_o && m_axil_awready_i;
    w_fire  = m_axil_wvalid_o && m_axil_wready_i;
    b_fire  = m_axil_bvalid_i && m_axil_bready_o;
    ar_fire = m_axil_arvalid_o && m_axil_arready_i;
    r_fire  = m_axil_rvalid_i && m_axil_rready_o;
    if (aw_fire)
      awaddr_q = m_axil_awaddr_o;
    if (w_fire)
    begin
      wdata_q = m_axil_wdata_o;
      wstrb_q = m_axil_wstrb_o;
    end
    if (ar_fire)
      araddr_q = m_axil_araddr_o;
  end

  initial
  begin
    #(watchdog_cycles_lp * clk_period_lp);
    $display("timeout: the tests did not finish within the expected time");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial
  begin
    void'($urandom(32'hc30c));
    errors = 0;
    checks = 0;
    tests_run = 0;
    stall_en = 1'b0;
    arst_n_i = 1'b0;
    mem_fwd_header_i = '0;
    mem_fwd_data_i = '0;
    mem_fwd_v_i = 1'b0;
    mem_rev_ready_and_i = 1'b0;
    {m_axil_awready_i, m_axil_wready_i, m_axil_arready_i} = 3'b000;
    {m_axil_bvalid_i, m_axil_rvalid_i} = 2'b00;
    m_axil_rdata_i = '0;
    {aw_have, w_have, ar_have} = 3'b000;
    {aw_fire, w_fire, b_fire, ar_fire, r_fire} = 5'b00000;
    awaddr_q = '0;
    araddr_q = '0;
    wdata_q = '0;
    wstrb_q = '0;
    for (int i = 0; i < 256; i++)
    begin
      axi_mem[i] = fill_word(8'(i));
      shadow[i]  = fill_word(8'(i));
    end
    repeat (10) @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);
    test_reset_idle();
    test_word_round_trip();
    test_sub_word_writes();
    test_sub_word_reads();
    test_back_pressure();
    test_payload_tags();
    $display("tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
rtl/me_axil_pkg.sv
rtl/fwd_decode.sv
rtl/axil_engine.sv
rtl/rev_pack.sv
rtl/me_axil_bridge.sv
verification/me_axil_chk.sv
verification/me_axil_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f compile.f \
  --top-module me_axil_tb \
  -o me_axil_sim \
  || { echo "build failed"; exit 1; }

./obj_dir/me_axil_sim | tee /dev/stderr | grep -F "TEST RESULT: PASS" > /dev/null \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed"; exit 1; }
